//--- common/fpMulPkg.sv
`default_nettype none

package fpMulPkg;

	// Half-precision format
	localparam int EXP_BITS = 5;
	localparam int FRAC_BITS = 10;
	localparam int EXP_BIAS = 15;
	localparam int HALF_BITS = 16;
	localparam int EXP_MAX = 31; // All-ones exponent, inf or NaN
	localparam int EXT_EXP_BITS = EXP_BITS + 2; // Signed exponent with headroom
	localparam int PROD_BITS = 2 * (FRAC_BITS + 1); // 11x11 significand product

	localparam logic [HALF_BITS-1:0] CANON_NAN = 16'h7E00; // Quiet NaN, no payload
	localparam logic [HALF_BITS-2:0] INF_MAG = 15'h7C00; // Infinity without sign
	localparam logic [HALF_BITS-2:0] MAX_MAG = 15'h7BFF; // Largest finite without sign

	// Result queue and credits
	localparam int QUEUE_DEPTH = 4; // Also the producer's starting credit
	localparam int OUT_CREDITS = 2; // Consumer's starting grant
	localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int COUNT_BITS = PTR_BITS + 1;
	localparam int CREDIT_BITS = $clog2(OUT_CREDITS + 1);

	// Register block
	localparam int CSR_BITS = 4;
	localparam logic CSR_CTRL = 1'b0; // Rounding mode in bit 0
	localparam logic CSR_FLAGS = 1'b1; // Sticky flags, write one to clear

	typedef enum logic {
		nearestEven = 1'b0,
		towardZero = 1'b1
	} roundMode;

	typedef struct packed {
		logic sign;
		logic [EXP_BITS-1:0] exp;
		logic [FRAC_BITS-1:0] frac;
	} fp16Fields;

	// Same word, raw or split into fields
	typedef union packed {
		logic [HALF_BITS-1:0] bits;
		fp16Fields f;
	} fp16Word;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpFlags;

	// Prep register contents, 37 bits
	typedef struct packed {
		logic sign; // Product sign
		logic [EXP_BITS-1:0] expA;
		logic [EXP_BITS-1:0] expB;
		logic [PROD_BITS-1:0] prod; // Significands with hidden ones
		logic isZero; // Either operand zero or subnormal
		logic isInf; // Either operand infinite
		logic isNan; // Either operand NaN
		logic invalid; // NaN in, or inf times zero
	} prepStage;

	typedef struct packed {
		fp16Word word;
		fpFlags flags;
	} resEntry;

endpackage

`default_nettype wire

//--- fpMul/fpMulPrep.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulPrep import fpMulPkg::*; (
	input fp16Word opA,
	input fp16Word opB,
	output prepStage stage
);

	logic aExpMax;
	logic bExpMax;
	logic aZero;
	logic bZero;
	logic aInf;
	logic bInf;
	logic aNan;
	logic bNan;
	logic anyZero;
	logic anyInf;
	logic anyNan;
	logic [FRAC_BITS:0] sigA;
	logic [FRAC_BITS:0] sigB;

	assign aExpMax = &opA.f.exp;
	assign bExpMax = &opB.f.exp;

	// Exponent zero covers subnormals too, they count as zero
	assign aZero = ~|opA.f.exp;
	assign bZero = ~|opB.f.exp;

	assign aInf = aExpMax & ~|opA.f.frac; // All ones, empty fraction
	assign bInf = bExpMax & ~|opB.f.frac;
	assign aNan = aExpMax & |opA.f.frac; // All ones, fraction set
	assign bNan = bExpMax & |opB.f.frac;

	assign anyZero = aZero | bZero;
	assign anyInf = aInf | bInf;
	assign anyNan = aNan | bNan;

	// Restore hidden ones
	assign sigA = {1'b1, opA.f.frac};
	assign sigB = {1'b1, opB.f.frac};

	assign stage.sign = opA.f.sign ^ opB.f.sign; // Equal signs give positive
	assign stage.expA = opA.f.exp;
	assign stage.expB = opB.f.exp;
	assign stage.prod = sigA * sigB; // Full 22-bit product
	assign stage.isZero = anyZero;
	assign stage.isInf = anyInf;
	assign stage.isNan = anyNan;
	assign stage.invalid = anyNan | (anyInf & anyZero); // Inf times zero has no answer

endmodule

`default_nettype wire

//--- fpMul/fpMulRound.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulRound import fpMulPkg::*; (
	input prepStage stage,
	input roundMode mode,
	output fp16Word word,
	output fpFlags flags
);

	logic topBit;
	logic [FRAC_BITS:0] normSig;
	logic guard;
	logic sticky;
	logic roundUp;
	logic [FRAC_BITS+1:0] roundSig;
	logic [FRAC_BITS-1:0] finalFrac;
	logic signed [EXT_EXP_BITS-1:0] normExp;
	logic signed [EXT_EXP_BITS-1:0] finalExp;
	logic tooBig;
	logic tooSmall;

	// Product in [1,4), top bit set means shift right by one
	assign topBit = stage.prod[PROD_BITS-1];
	assign normSig = topBit ? stage.prod[PROD_BITS-1 -: FRAC_BITS+1]
		: stage.prod[PROD_BITS-2 -: FRAC_BITS+1];
	assign guard = topBit ? stage.prod[FRAC_BITS] : stage.prod[FRAC_BITS-1];
	assign sticky = topBit ? |stage.prod[FRAC_BITS-1:0] : |stage.prod[FRAC_BITS-2:0];

	// Sum of biased exponents, one bias removed
	assign normExp = {2'b00, stage.expA} + {2'b00, stage.expB}
		+ {{(EXT_EXP_BITS-1){1'b0}}, topBit} - EXT_EXP_BITS'(EXP_BIAS);

	// Ties go to even, toward zero just truncates
	assign roundUp = (mode == nearestEven) & guard & (sticky | normSig[0]);
	assign roundSig = {1'b0, normSig} + {{(FRAC_BITS+1){1'b0}}, roundUp};

	// Carry out of rounding leaves 10.000..., shift and bump exponent
	assign finalFrac = roundSig[FRAC_BITS+1] ? roundSig[FRAC_BITS:1] : roundSig[FRAC_BITS-1:0];
	assign finalExp = normExp + {{(EXT_EXP_BITS-1){1'b0}}, roundSig[FRAC_BITS+1]};

	assign tooBig = finalExp >= EXP_MAX;
	assign tooSmall = finalExp <= 0; // No subnormal results

	always_comb begin
		word.bits = '0;
		flags = '0;
		if (stage.invalid) begin
			word.bits = CANON_NAN;
			flags.invalid = 1'b1;
		end else if (stage.isInf) begin // Inf times nonzero finite
			word.bits = {stage.sign, INF_MAG};
		end else if (stage.isZero) begin
			word.f.sign = stage.sign; // Signed exact zero
		end else if (tooBig) begin
			// Toward zero saturates at the largest finite
			word.bits = {stage.sign, (mode == towardZero) ? MAX_MAG : INF_MAG};
			flags.overflow = 1'b1;
			flags.inexact = 1'b1; // Whole value lost
		end else if (tooSmall) begin
			word.f.sign = stage.sign;
			flags.underflow = 1'b1;
			flags.inexact = 1'b1; // Nonzero product flushed
		end else begin
			word.f.sign = stage.sign;
			word.f.exp = finalExp[EXP_BITS-1:0];
			word.f.frac = finalFrac;
			flags.inexact = guard | sticky; // Any dropped bit
		end
	end

endmodule

`default_nettype wire

//--- fpMul/fpMulPipe.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulPipe import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fp16Word opA,
	input fp16Word opB,
	input roundMode mode,
	output logic resValid,
	output fp16Word resWord,
	output fpFlags resFlags
);

	// Stage 1, operand register
	logic s1Valid;
	fp16Word s1OpA;
	fp16Word s1OpB;

	// Stage 2, prep register
	logic s2Valid;
	prepStage s2Stage;
	prepStage prepOut;

	// Round logic output, into stage 3
	fp16Word roundWord;
	fpFlags roundFlags;

	fpMulPrep fpMulPrep_i (
		.opA(s1OpA),
		.opB(s1OpB),
		.stage(prepOut)
	);

	// Mode is picked up as the item enters stage 3
	fpMulRound fpMulRound_i (
		.stage(s2Stage),
		.mode(mode),
		.word(roundWord),
		.flags(roundFlags)
	);

	// Valid bits walk with each item
	always_ff @(posedge clk) begin
		if (rst) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			resValid <= 1'b0;
		end else begin
			s1Valid <= inValid;
			s2Valid <= s1Valid;
			resValid <= s2Valid;
		end
	end

	// Data only moves under its valid
	always_ff @(posedge clk) begin
		if (inValid) begin
			s1OpA <= opA;
			s1OpB <= opB;
		end
		if (s1Valid) begin
			s2Stage <= prepOut;
		end
		if (s2Valid) begin
			resWord <= roundWord; // Packed result
			resFlags <= roundFlags;
		end
	end

endmodule

`default_nettype wire

//--- source/fpMulCsr.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulCsr import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic csrWrite,
	input logic csrAddr,
	input logic [CSR_BITS-1:0] csrWdata,
	input logic resValid,
	input fpFlags resFlags,
	output logic [CSR_BITS-1:0] csrRdata,
	output roundMode mode
);

	fpFlags sticky;
	fpFlags clearMask;
	fpFlags newFlags;
	logic ctrlWrite;

	assign ctrlWrite = csrWrite && (csrAddr == CSR_CTRL);

	// Ones written to the flag address clear those bits
	assign clearMask = (csrWrite && (csrAddr == CSR_FLAGS)) ? fpFlags'(csrWdata) : '0;

	assign newFlags = resValid ? resFlags : '0; // Only completed results count

	// Rounding mode register
	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= nearestEven;
		end else if (ctrlWrite) begin
			mode <= roundMode'(csrWdata[0]);
		end
	end

	// Clear first, then OR in, so a fresh flag survives a same-cycle clear
	always_ff @(posedge clk) begin
		if (rst) begin
			sticky <= '0;
		end else begin
			sticky <= (sticky & ~clearMask) | newFlags;
		end
	end

	// Read data one cycle after the address
	always_ff @(posedge clk) begin
		if (rst) begin
			csrRdata <= '0;
		end else if (csrAddr == CSR_CTRL) begin
			csrRdata <= {{(CSR_BITS-1){1'b0}}, mode};
		end else begin
			csrRdata <= sticky; // invalid, overflow, underflow, inexact
		end
	end

endmodule

`default_nettype wire

//--- source/fpMulResultQueue.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulResultQueue import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic resValid,
	input fp16Word resWord,
	input fpFlags resFlags,
	input logic outCredit,
	output logic outValid,
	output fp16Word outResult,
	output fpFlags outFlags,
	output logic inCredit
);

	resEntry mem [QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [COUNT_BITS-1:0] count; // Entries held
	logic [CREDIT_BITS-1:0] credits; // Downstream credits held
	logic pop;

	// Head leaves only while the consumer has room
	assign pop = (count != '0) && (credits != '0);

	// Storage, pointers wrap on a power-of-two depth
	always_ff @(posedge clk) begin
		if (resValid) begin
			mem[wrPtr] <= '{word: resWord, flags: resFlags};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (resValid) begin
				wrPtr <= wrPtr + PTR_BITS'(1);
			end
			if (pop) begin
				rdPtr <= rdPtr + PTR_BITS'(1);
			end
			case ({resValid, pop})
				2'b10: count <= count + COUNT_BITS'(1);
				2'b01: count <= count - COUNT_BITS'(1);
				default: count <= count; // Idle or push with pop
			endcase
		end
	end

	// Credit returned in the same cycle as a spend nets out
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_BITS'(OUT_CREDITS);
		end else begin
			case ({outCredit, pop})
				2'b10: credits <= credits + CREDIT_BITS'(1);
				2'b01: credits <= credits - CREDIT_BITS'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Output valid and upstream credit pulse together
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			inCredit <= 1'b0;
		end else begin
			outValid <= pop;
			inCredit <= pop; // Slot freed, producer may send again
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			outResult <= mem[rdPtr].word;
			outFlags <= mem[rdPtr].flags;
		end
	end

endmodule

`default_nettype wire

//--- source/fpMulTop.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulTop import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fp16Word opA,
	input fp16Word opB,
	input logic outCredit,
	input logic csrWrite,
	input logic csrAddr,
	input logic [CSR_BITS-1:0] csrWdata,
	output logic inCredit,
	output logic outValid,
	output fp16Word outResult,
	output fpFlags outFlags,
	output logic [CSR_BITS-1:0] csrRdata
);

	logic resValid;
	fp16Word resWord;
	fpFlags resFlags;
	roundMode mode;

	// Three-stage multiplier, no stall
	fpMulPipe fpMulPipe_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.opA(opA),
		.opB(opB),
		.mode(mode),
		.resValid(resValid),
		.resWord(resWord),
		.resFlags(resFlags)
	);

	// Mode and sticky flags
	fpMulCsr fpMulCsr_i (
		.clk(clk),
		.rst(rst),
		.csrWrite(csrWrite),
		.csrAddr(csrAddr),
		.csrWdata(csrWdata),
		.resValid(resValid), // Flags gathered as results complete
		.resFlags(resFlags),
		.csrRdata(csrRdata),
		.mode(mode)
	);

	// Absorbs results while the consumer holds back credits
	fpMulResultQueue fpMulResultQueue_i (
		.clk(clk),
		.rst(rst),
		.resValid(resValid),
		.resWord(resWord),
		.resFlags(resFlags),
		.outCredit(outCredit),
		.outValid(outValid),
		.outResult(outResult),
		.outFlags(outFlags),
		.inCredit(inCredit)
	);

endmodule

`default_nettype wire

//--- test/fpMulRefModel.svh
`ifndef FP_MUL_REF_MODEL_SVH
`define FP_MUL_REF_MODEL_SVH

// Expected word and flags for a times b from the half-precision rules
function automatic resEntry refMultiply(input fp16Word a, input fp16Word b, input roundMode rm);
	resEntry r;
	logic sign;
	logic aNan;
	logic bNan;
	logic aInf;
	logic bInf;
	logic anyZero;
	int unsigned prod;
	int unsigned mant;
	int unsigned rem;
	int unsigned half;
	int shift;
	int e;
	r = '0;
	sign = a.f.sign ^ b.f.sign;
	aNan = (a.f.exp == 5'h1f) && (a.f.frac != 10'h0);
	bNan = (b.f.exp == 5'h1f) && (b.f.frac != 10'h0);
	aInf = (a.f.exp == 5'h1f) && (a.f.frac == 10'h0);
	bInf = (b.f.exp == 5'h1f) && (b.f.frac == 10'h0);
	anyZero = (a.f.exp == 5'h00) || (b.f.exp == 5'h00); // Subnormals flush to zero
	if (aNan || bNan || ((aInf || bInf) && anyZero)) begin
		r.word.bits = 16'h7e00; // Canonical quiet NaN
		r.flags.invalid = 1'b1;
		return r;
	end
	if (aInf || bInf) begin
		r.word.bits = {sign, 15'h7c00};
		return r;
	end
	if (anyZero) begin
		r.word.bits = {sign, 15'h0000};
		return r;
	end
	// Integer significands with value prod times 2^(ea+eb-50)
	prod = (32'd1024 + a.f.frac) * (32'd1024 + b.f.frac);
	shift = (prod >= 32'h0020_0000) ? 11 : 10; // Keep 11 significant bits
	mant = prod >> shift;
	rem = prod - (mant << shift); // Bits dropped
	half = 32'd1 << (shift - 1);
	e = int'(a.f.exp) + int'(b.f.exp) - 15 + shift - 10;
	// Above half goes up and exactly half goes to the even neighbour
	if (rm == nearestEven && (rem > half || (rem == half && mant[0]))) begin
		mant = mant + 1;
	end
	if (mant == 32'd2048) begin // Rounded up to the next power of two
		mant = 32'd1024;
		e = e + 1;
	end
	if (e >= 31) begin
		r.word.bits = {sign, (rm == towardZero) ? 15'h7bff : 15'h7c00};
		r.flags.overflow = 1'b1;
		r.flags.inexact = 1'b1;
	end else if (e <= 0) begin
		r.word.bits = {sign, 15'h0000}; // No subnormal results
		r.flags.underflow = 1'b1;
		r.flags.inexact = 1'b1;
	end else begin
		r.word.bits = {sign, e[4:0], mant[9:0]};
		r.flags.inexact = (rem != 0);
	end
	return r;
endfunction

`endif

//--- test/fpMulTb.sv
`timescale 1ns/1ns
`default_nettype none

module fpMulTb import fpMulPkg::*; ();

	localparam int TIMEOUT = 2000; // Cycles allowed per wait

	typedef struct packed {
		fp16Word a;
		fp16Word b;
		resEntry res;
	} expectItem;

	logic clk;
	logic rst;
	logic inValid;
	fp16Word opA;
	fp16Word opB;
	logic outCredit = 1'b0; // Driven by the consumer process
	logic csrWrite;
	logic csrAddr;
	logic [CSR_BITS-1:0] csrWdata;
	logic inCredit;
	logic outValid;
	fp16Word outResult;
	fpFlags outFlags;
	logic [CSR_BITS-1:0] csrRdata;

	expectItem expQ[$]; // Issued but not yet delivered
	logic [31:0] lcgState = 32'hf04a_0022;
	roundMode curMode = nearestEven;
	fpFlags stickyModel = '0; // OR of expected flags since last clear
	int issued = 0;
	int creditsBack = 0; // inCredit pulses seen
	int resultsSeen = 0;
	int delivered = 0;
	int inCreditCount = 0;
	int grantNow = OUT_CREDITS; // Credits handed to the DUT so far
	int grantLag = OUT_CREDITS; // Same count one edge older
	int owed = 0; // Credits the consumer still has to return
	logic holdCredits = 1'b0;

	// a in the upper half and b in the lower
	logic [31:0] specials [24] = '{
		32'h7e00_3c00, 32'h7c01_3c00, 32'h3c00_fe00, // NaN inputs
		32'h7c00_0000, 32'h0000_fc00, 32'h7c00_0001, // Inf times zero
		32'h7c00_4000, 32'hfc00_3c00, 32'h7c00_fc00, // Inf times finite
		32'h0000_3c00, 32'h8000_3c00, 32'h0001_7bff, 32'h83ff_4000,
		32'h7bff_7bff, 32'h7800_4000, 32'h7bff_3c01, 32'hfbff_4000, // Overflow
		32'h0400_0400, 32'h8400_0400, 32'h07ff_37ff, // Underflow
		32'h3c00_3c00, 32'h3e00_3e00, 32'h3c01_3e00, 32'h3c03_3e00 // Exact and ties
	};

	fpMulTop fpMulTop_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stopRun();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic reportMismatch(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		stopRun();
	endtask

	task automatic reportStall(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		stopRun();
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Exponents 3..27 so products reach both overflow and underflow
	function automatic fp16Word randomNormal();
		logic [31:0] r;
		fp16Word w;
		r = nextRand();
		w.f.sign = r[31];
		w.f.exp = 5'(3 + r[30:24] % 25);
		w.f.frac = r[23:14];
		return w;
	endfunction

	task automatic issuePair(input fp16Word a, input fp16Word b);
		int waited;
		expectItem item;
		waited = 0;
		@(posedge clk);
		while (issued - creditsBack >= QUEUE_DEPTH) begin // Out of producer credits
			inValid <= 1'b0;
			waited++;
			if (waited > TIMEOUT) reportStall("a producer credit");
			@(posedge clk);
		end
		item.a = a;
		item.b = b;
		item.res = refMultiply(a, b, curMode);
		expQ.push_back(item);
		stickyModel = stickyModel | item.res.flags;
		issued++;
		inValid <= 1'b1;
		opA <= a;
		opB <= b;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (resultsSeen != issued) begin
			@(posedge clk);
			inValid <= 1'b0;
			waited++;
			if (waited > TIMEOUT) reportStall("outstanding results");
		end
	endtask

	task automatic writeCsr(input logic addr, input logic [CSR_BITS-1:0] data);
		@(posedge clk);
		csrWrite <= 1'b1;
		csrAddr <= addr;
		csrWdata <= data;
		@(posedge clk);
		csrWrite <= 1'b0;
	endtask

	task automatic readCsr(input logic addr, output logic [CSR_BITS-1:0] data);
		@(posedge clk);
		csrAddr <= addr;
		repeat (2) @(posedge clk); // Read data is registered
		data = csrRdata;
	endtask

	// Compare, clear part, compare, clear rest
	task automatic checkSticky(input string phase);
		logic [CSR_BITS-1:0] data;
		readCsr(CSR_FLAGS, data);
		assert (data == stickyModel) else reportMismatch($sformatf(
			"%s: sticky flags %b, expected %b", phase, data, stickyModel));
		writeCsr(CSR_FLAGS, 4'b1010); // invalid and underflow
		stickyModel = stickyModel & ~4'b1010;
		readCsr(CSR_FLAGS, data);
		assert (data == stickyModel) else reportMismatch($sformatf(
			"%s: after partial clear %b, expected %b", phase, data, stickyModel));
		writeCsr(CSR_FLAGS, 4'hf);
		stickyModel = '0;
		readCsr(CSR_FLAGS, data);
		assert (data == 4'h0) else reportMismatch($sformatf(
			"%s: flags %b after full clear", phase, data));
	endtask

	task automatic setMode(input roundMode m);
		logic [CSR_BITS-1:0] data;
		writeCsr(CSR_CTRL, {3'b000, m});
		curMode = m;
		readCsr(CSR_CTRL, data);
		assert (data == {3'b000, m}) else reportMismatch($sformatf(
			"mode reads %b after writing %b", data, m));
	endtask

	// Consumer returns one credit per result unless holding back
	always @(posedge clk) begin
		if (rst) begin
			owed = 0;
			outCredit <= 1'b0;
		end else begin
			if (outValid) owed++;
			if (!holdCredits && owed > 0) begin
				outCredit <= 1'b1;
				owed--;
			end else begin
				outCredit <= 1'b0;
			end
		end
	end

	// Result and credit checks
	always @(posedge clk) begin
		expectItem head;
		if (!rst) begin
			if (outValid) begin
				delivered++;
				assert (delivered <= grantLag) else
					reportMismatch("outValid while no downstream credit was held");
				assert (expQ.size() > 0) else reportMismatch("outValid with no result outstanding");
				head = expQ.pop_front();
				assert (outResult == head.res.word && outFlags == head.res.flags) else
					reportMismatch($sformatf("%h * %h gave %h flags %b, expected %h flags %b",
						head.a, head.b, outResult, outFlags, head.res.word, head.res.flags));
				resultsSeen <= resultsSeen + 1;
			end
			grantLag = grantNow;
			if (outCredit) grantNow++;
			if (inCredit) begin
				inCreditCount++;
				creditsBack <= creditsBack + 1;
			end
			assert (inCreditCount <= delivered) else
				reportMismatch("more inCredit pulses than delivered results");
		end
	end

	initial begin
		fp16Word a;
		fp16Word b;
		logic [CSR_BITS-1:0] data;
		int holdLen [4];
		rst = 1'b1;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		csrWrite = 1'b0;
		csrAddr = CSR_CTRL;
		csrWdata = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Quiet after reset
		repeat (12) begin
			@(posedge clk);
			assert (!outValid && !inCredit) else reportMismatch("output activity before any operand");
		end
		readCsr(CSR_CTRL, data);
		assert (data == {3'b000, nearestEven}) else reportMismatch("mode not nearestEven after reset");
		readCsr(CSR_FLAGS, data);
		assert (data == 4'h0) else reportMismatch("sticky flags set after reset");

		for (int i = 0; i < 300; i++) begin
			a = randomNormal();
			b = randomNormal();
			issuePair(a, b);
		end
		drain();
		checkSticky("random nearest even");

		foreach (specials[i]) issuePair(specials[i][31:16], specials[i][15:0]);
		drain();
		checkSticky("directed specials");

		// Truncation mode where overflow saturates
		setMode(towardZero);
		for (int i = 0; i < 200; i++) begin
			a = randomNormal();
			b = randomNormal();
			issuePair(a, b);
		end
		foreach (specials[i]) issuePair(specials[i][31:16], specials[i][15:0]);
		drain();
		checkSticky("toward zero");
		setMode(nearestEven);

		// Back-pressure with the consumer sitting on its credits for long stretches
		foreach (holdLen[k]) holdLen[k] = 60 + int'(nextRand() >> 24);
		fork
			begin
				for (int i = 0; i < 120; i++) begin
					a = randomNormal();
					b = randomNormal();
					issuePair(a, b);
				end
				@(posedge clk);
				inValid <= 1'b0; // Last pair taken, producer goes idle
			end
			for (int k = 0; k < 4; k++) begin
				@(posedge clk);
				holdCredits <= 1'b1;
				repeat (holdLen[k]) @(posedge clk);
				holdCredits <= 1'b0;
				repeat (20) @(posedge clk);
			end
		join
		drain();
		checkSticky("back-pressure");
		assert (creditsBack == resultsSeen) else reportMismatch($sformatf(
			"%0d inCredit pulses for %0d results", creditsBack, resultsSeen));

		$display("*** TEST PASSED ***");
		$finish;
	end

`include "fpMulRefModel.svh"

endmodule

`default_nettype wire

//--- files.f
+incdir+test
common/fpMulPkg.sv
fpMul/fpMulPrep.sv
fpMul/fpMulRound.sv
fpMul/fpMulPipe.sv
source/fpMulCsr.sv
source/fpMulResultQueue.sv
source/fpMulTop.sv
test/fpMulTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = fpMulTb
FILELIST = files.f

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
